// File: ping_pong_counter.f
source/counter_pkg.sv
source/display_pkg.sv
source/tick_generator.sv
source/input_debouncer.sv
source/ping_pong_core.sv
source/display_scanner.sv
source/ping_pong_counter.sv
testbench/ping_pong_counter_checker.sv
testbench/ping_pong_counter_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the ping-pong counter testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ping_pong_counter_tb \
    -f ping_pong_counter.f \
    -o ping_pong_counter_sim

./obj_dir/ping_pong_counter_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
else
    exit 1
fi

// File: source/counter_pkg.sv
`default_nettype none

package counter_pkg;

    // ****************************************
    // Timing constants, kept small for simulation.
    // ****************************************
    localparam int COUNT_WIDTH       = 4;
    localparam int COUNT_TICK_PERIOD = 16;
    localparam int DEBOUNCE_DEPTH    = 4;

    // ****************************************
    // Counter types.
    // ****************************************
    typedef logic [COUNT_WIDTH-1:0] count_t;

    typedef enum logic {
        dir_down = 1'b0,
        dir_up   = 1'b1
    } direction_t;

    // Board switches, enable on the top bit.
    typedef struct packed {
        logic   enable;
        count_t max_value;
        count_t min_value;
    } switch_settings_t;

    typedef struct packed {
        count_t     count;
        direction_t direction;
    } counter_state_t;

endpackage

`default_nettype wire

// File: source/display_pkg.sv
`default_nettype none

package display_pkg;

    // ****************************************
    // Scan constants.
    // ****************************************
    localparam int SCAN_TICK_PERIOD = 2;
    localparam int NUM_DIGITS       = 4;

    typedef logic [$clog2(NUM_DIGITS)-1:0] digit_index_t;

    // Both active low.
    typedef logic [6:0] segments_t;
    typedef logic [NUM_DIGITS-1:0] anodes_t;

    localparam segments_t SEGMENTS_OFF = 7'b1111111;
    localparam anodes_t   ANODES_OFF   = 4'b1111;

    // ****************************************
    // Pattern tables.
    // ****************************************
    localparam segments_t DIGIT_PATTERNS [10] = '{
        7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110, 7'b1001100,
        7'b0100100, 7'b0100000, 7'b0001111, 7'b0000000, 7'b0000100
    };

    localparam segments_t ARROW_UP   = 7'b0011101;
    localparam segments_t ARROW_DOWN = 7'b1100011;

    // Leftmost digit first.
    localparam anodes_t ANODE_PATTERNS [NUM_DIGITS] = '{
        4'b0111, 4'b1011, 4'b1101, 4'b1110
    };

endpackage

`default_nettype wire

// File: source/display_scanner.sv
`default_nettype none
`timescale 1ns/10ps

module display_scanner
    import counter_pkg::*;
    import display_pkg::*;
(
    input  logic           clk,
    input  logic           rstn_out,
    input  logic           scan_tick,
    input  counter_state_t state,
    output segments_t      seg,
    output anodes_t        an
);

    digit_index_t digit_idx;
    logic         scanning;
    logic         tens;
    count_t       ones;
    segments_t    seg_next;

    always_ff @(posedge clk) begin
        if (rstn_out) begin
            digit_idx <= '0;
            scanning  <= 1'b0;
        end else if (scan_tick) begin
            digit_idx <= digit_idx + 1'b1;
            scanning  <= 1'b1;
        end
    end

    // Tens and ones split.
    assign tens = (state.count >= count_t'(10));
    assign ones = tens ? state.count - count_t'(10) : state.count;

    always_comb begin
        case (digit_idx)
            2'd0: seg_next = tens ? DIGIT_PATTERNS[1] : DIGIT_PATTERNS[0];
            2'd1: seg_next = DIGIT_PATTERNS[ones];
            default: begin
                seg_next = (state.direction == dir_up) ? ARROW_UP : ARROW_DOWN;
            end
        endcase
    end

    // Dark until the first scan step.
    always_ff @(posedge clk) begin
        if (rstn_out) begin
            seg <= SEGMENTS_OFF;
            an  <= ANODES_OFF;
        end else if (scanning) begin
            seg <= seg_next;
            an  <= ANODE_PATTERNS[digit_idx];
        end
    end

endmodule

`default_nettype wire

// File: source/input_debouncer.sv
`default_nettype none
`timescale 1ns/10ps

module input_debouncer
    import counter_pkg::*;
#(
    parameter type signal_t = logic
) (
    input  logic    clk,
    input  logic    rstn_out,
    input  signal_t raw,
    output signal_t stable
);

    signal_t history [DEBOUNCE_DEPTH];
    logic    all_equal;

    always_ff @(posedge clk) begin
        if (rstn_out) begin
            for (int i = 0; i < DEBOUNCE_DEPTH; i++) begin
                history[i] <= '0;
            end
        end else begin
            history[0] <= raw;
            for (int i = 1; i < DEBOUNCE_DEPTH; i++) begin
                history[i] <= history[i-1];
            end
        end
    end

    // Whole history must agree.
    always_comb begin
        all_equal = 1'b1;
        for (int i = 1; i < DEBOUNCE_DEPTH; i++) begin
            if (history[i] != history[0]) begin
                all_equal = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rstn_out) begin
            stable <= '0;
        end else if (all_equal) begin
            stable <= history[DEBOUNCE_DEPTH-1];
        end
    end

endmodule

`default_nettype wire

// File: source/ping_pong_core.sv
`default_nettype none
`timescale 1ns/10ps

module ping_pong_core
    import counter_pkg::*;
(
    input  logic             clk,
    input  logic             rstn_out,
    input  logic             count_tick,
    input  logic             flip_level,
    input  switch_settings_t settings,
    output counter_state_t   state
);

    logic           flip_level_q;
    logic           flip_pending;
    logic           first_tick;
    logic           active;
    logic           consume_flip;
    counter_state_t next_state;

    // ****************************************
    // Flip capture.
    // ****************************************
    always_ff @(posedge clk) begin
        if (rstn_out) begin
            flip_level_q <= 1'b0;
            flip_pending <= 1'b0;
        end else begin
            flip_level_q <= flip_level;
            if (flip_level && !flip_level_q) begin
                flip_pending <= 1'b1;
            end else if (consume_flip) begin
                flip_pending <= 1'b0;
            end
        end
    end

    // ****************************************
    // Next count and direction.
    // ****************************************
    assign active = settings.enable
                 && (settings.max_value > settings.min_value)
                 && (state.count >= settings.min_value)
                 && (state.count <= settings.max_value);

    assign consume_flip = count_tick && !first_tick && active && flip_pending;

    always_comb begin
        next_state = state;
        if (first_tick) begin
            next_state.count     = settings.min_value;
            next_state.direction = dir_up;
        end else if (active) begin
            if (flip_pending) begin
                // Reverse first, then step. Stuck at the far bound means no change.
                if (state.direction == dir_up && state.count > settings.min_value) begin
                    next_state.count     = state.count - 1'b1;
                    next_state.direction = dir_down;
                end else if (state.direction == dir_down
                             && state.count < settings.max_value) begin
                    next_state.count     = state.count + 1'b1;
                    next_state.direction = dir_up;
                end
            end else if (state.direction == dir_up) begin
                if (state.count == settings.max_value) begin
                    next_state.count     = settings.max_value - 1'b1;
                    next_state.direction = dir_down;
                end else begin
                    next_state.count = state.count + 1'b1;
                end
            end else begin
                if (state.count == settings.min_value) begin
                    next_state.count     = settings.min_value + 1'b1;
                    next_state.direction = dir_up;
                end else begin
                    next_state.count = state.count - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rstn_out) begin
            state.count     <= settings.min_value;
            state.direction <= dir_up;
            first_tick      <= 1'b1;
        end else if (count_tick) begin
            state      <= next_state;
            first_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/ping_pong_counter.sv
`default_nettype none
`timescale 1ns/10ps

module ping_pong_counter
    import counter_pkg::*;
    import display_pkg::*;
(
    input  logic             clk,
    input  logic             rstn_out,
    input  logic             flip_button,
    input  switch_settings_t switches,
    output segments_t        seg,
    output anodes_t          an
);

    logic             count_tick;
    logic             scan_tick;
    logic             flip_level;
    switch_settings_t stable_settings;
    counter_state_t   state;

    tick_generator u_tick_generator (
        .clk        (clk),
        .rstn_out   (rstn_out),
        .count_tick (count_tick),
        .scan_tick  (scan_tick)
    );

    // ****************************************
    // Input conditioning.
    // ****************************************
    input_debouncer #(
        .signal_t (switch_settings_t)
    ) u_settings_debouncer (
        .clk      (clk),
        .rstn_out (rstn_out),
        .raw      (switches),
        .stable   (stable_settings)
    );

    input_debouncer #(
        .signal_t (logic)
    ) u_button_debouncer (
        .clk      (clk),
        .rstn_out (rstn_out),
        .raw      (flip_button),
        .stable   (flip_level)
    );

    ping_pong_core u_core (
        .clk        (clk),
        .rstn_out   (rstn_out),
        .count_tick (count_tick),
        .flip_level (flip_level),
        .settings   (stable_settings),
        .state      (state)
    );

    display_scanner u_scanner (
        .clk       (clk),
        .rstn_out  (rstn_out),
        .scan_tick (scan_tick),
        .state     (state),
        .seg       (seg),
        .an        (an)
    );

endmodule

`default_nettype wire

// File: source/tick_generator.sv
`default_nettype none
`timescale 1ns/10ps

module tick_generator
    import counter_pkg::*;
    import display_pkg::*;
(
    input  logic clk,
    input  logic rstn_out,
    output logic count_tick,
    output logic scan_tick
);

    localparam int TICK_PERIODS [2] = '{COUNT_TICK_PERIOD, SCAN_TICK_PERIOD};

    logic [1:0] ticks;

    // One wrapping counter per tick, pulse on the wrap.
    for (genvar i = 0; i < 2; i++) begin : gen_tick
        localparam int PERIOD = TICK_PERIODS[i];
        localparam int WIDTH  = $clog2(PERIOD);

        logic [WIDTH-1:0] cnt;
        logic             tick;

        always_ff @(posedge clk) begin
            if (rstn_out) begin
                cnt  <= '0;
                tick <= 1'b0;
            end else if (cnt == WIDTH'(PERIOD - 1)) begin
                cnt  <= '0;
                tick <= 1'b1;
            end else begin
                cnt  <= cnt + 1'b1;
                tick <= 1'b0;
            end
        end

        assign ticks[i] = tick;
    end

    assign count_tick = ticks[0];
    assign scan_tick  = ticks[1];

endmodule

`default_nettype wire

// File: testbench/ping_pong_counter_checker.sv
`default_nettype none
`timescale 1ns/10ps

module ping_pong_counter_checker
    import counter_pkg::*;
(
    input logic             clk,
    input logic             rstn_out,
    input logic             count_tick,
    input logic             first_tick,
    input switch_settings_t settings,
    input counter_state_t   state
);

    function automatic logic in_range(input switch_settings_t s, input count_t c);
        return s.enable && (s.max_value > s.min_value)
            && (c >= s.min_value) && (c <= s.max_value);
    endfunction

    // Range kept while the bounds are valid.
    assert property (@(posedge clk) disable iff (rstn_out)
        (count_tick && !first_tick && in_range(settings, state.count))
        |=> in_range($past(settings), state.count))
    else $error("count left the range between min_value and max_value");

    // State moves only on a tick.
    assert property (@(posedge clk) disable iff (rstn_out)
        !count_tick |=> $stable(state))
    else $error("state changed without a count tick");

    // Steps of one.
    assert property (@(posedge clk) disable iff (rstn_out)
        (count_tick && !first_tick && in_range(settings, state.count))
        |=> (state.count == $past(state.count))
         || (state.count == count_t'($past(state.count) + 1'b1))
         || (state.count == count_t'($past(state.count) - 1'b1)))
    else $error("count stepped by more than one");

endmodule

bind ping_pong_core ping_pong_counter_checker checker_inst (
    .clk        (clk),
    .rstn_out   (rstn_out),
    .count_tick (count_tick),
    .first_tick (first_tick),
    .settings   (settings),
    .state      (state)
);

`default_nettype wire

// File: testbench/ping_pong_counter_tb.sv
`default_nettype none
`timescale 1ns/10ps

module ping_pong_counter_tb
    import counter_pkg::*;
    import display_pkg::*;
;

    typedef struct packed {
        switch_settings_t settings;
        logic             flip;
        logic [4:0]       periods;
        count_t           exp_count;
        direction_t       exp_dir;
    } row_t;

    localparam int FLIP_HOLD   = DEBOUNCE_DEPTH + 2;
    localparam int RANDOM_ROWS = 6;
    localparam int MARGIN      = 200;

    logic             clk;
    logic             rstn_out;
    logic             flip_button;
    switch_settings_t switches;
    segments_t        seg;
    anodes_t          an;

    row_t        rows[$];
    int          table_rows;
    int          cycle_count;
    int          cycle_limit;
    int          press_left;
    logic [15:0] lfsr_state;
    count_t      model_count;
    direction_t  model_dir;
    logic        model_pending;
    logic        model_first;

    ping_pong_counter dut (
        .clk         (clk),
        .rstn_out    (rstn_out),
        .flip_button (flip_button),
        .switches    (switches),
        .seg         (seg),
        .an          (an)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    // ****************************************
    // Cycle stepping and tick sync.
    // ****************************************
    task automatic step_cycle();
        @(posedge clk);
        #5;
        cycle_count++;
        if (press_left > 0) begin
            press_left--;
            if (press_left == 0) begin
                flip_button = 1'b0;
            end
        end
        if (cycle_count > cycle_limit) begin
            fail_run("Timeout: the count ticks stopped before all rows were applied");
        end
    endtask

    task automatic wait_tick();
        do begin
            step_cycle();
        end while (!dut.count_tick);
    endtask

    // 16-bit Galois LFSR.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 16'hB400;
        end
        return s;
    endfunction

    function automatic logic [7:0] next_bits(input int n);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        return bits;
    endfunction

    // ****************************************
    // Reference model for one count tick.
    // ****************************************
    task automatic model_tick(input switch_settings_t s);
        logic active;
        active = s.enable && (s.max_value > s.min_value)
              && (model_count >= s.min_value) && (model_count <= s.max_value);
        if (model_first) begin
            model_first = 1'b0;
            model_count = s.min_value;
            model_dir   = dir_up;
        end else if (active && model_pending) begin
            model_pending = 1'b0;
            if (model_dir == dir_up && model_count != s.min_value) begin
                model_count = model_count - 4'd1;
                model_dir   = dir_down;
            end else if (model_dir == dir_down && model_count != s.max_value) begin
                model_count = model_count + 4'd1;
                model_dir   = dir_up;
            end
        end else if (active && model_dir == dir_up) begin
            if (model_count == s.max_value) begin
                model_count = s.max_value - 4'd1;
                model_dir   = dir_down;
            end else begin
                model_count = model_count + 4'd1;
            end
        end else if (active) begin
            if (model_count == s.min_value) begin
                model_count = s.min_value + 4'd1;
                model_dir   = dir_up;
            end else begin
                model_count = model_count - 4'd1;
            end
        end
    endtask

    task automatic add_row(input logic en, input int max_v, input int min_v, input logic flip,
                           input int periods, input int exp_c, input direction_t exp_d);
        row_t r;
        r.settings.enable    = en;
        r.settings.max_value = count_t'(max_v);
        r.settings.min_value = count_t'(min_v);
        r.flip               = flip;
        r.periods            = 5'(periods);
        r.exp_count          = count_t'(exp_c);
        r.exp_dir            = exp_d;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(1, 6, 2, 0, 1, 2, dir_up);
        add_row(1, 6, 2, 0, 4, 6, dir_up);
        add_row(1, 6, 2, 0, 1, 5, dir_down);
        add_row(1, 6, 2, 0, 3, 2, dir_down);
        add_row(1, 6, 2, 0, 1, 3, dir_up);
        add_row(1, 6, 2, 0, 10, 5, dir_up);
        add_row(1, 6, 2, 1, 1, 4, dir_down);
        add_row(1, 6, 2, 1, 1, 5, dir_up);
        add_row(1, 6, 2, 0, 1, 6, dir_up);
        add_row(1, 6, 2, 0, 4, 2, dir_down);
        add_row(1, 6, 2, 0, 1, 3, dir_up);
        add_row(1, 6, 3, 1, 1, 3, dir_up);
        add_row(0, 6, 3, 1, 3, 3, dir_up);
        add_row(1, 4, 4, 0, 2, 3, dir_up);
        add_row(1, 6, 2, 0, 1, 2, dir_down);
        add_row(1, 15, 2, 0, 11, 13, dir_up);
        add_row(1, 15, 2, 0, 3, 14, dir_down);
        table_rows = rows.size();
        // Random valid bounds. The model fills in the expected values.
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            add_row(1, 8 + int'(next_bits(3)), int'(next_bits(3)), next_bits(1) != 0,
                    1 + int'(next_bits(2)), 0, dir_up);
        end
    endtask

    task automatic apply_row(input row_t r);
        switches = r.settings;
        if (r.flip) begin
            flip_button   = 1'b1;
            press_left    = FLIP_HOLD;
            model_pending = 1'b1;
        end
    endtask

    // ****************************************
    // Display decoding and compare tasks.
    // ****************************************
    task automatic check_display_pattern(input segments_t pattern, output int value);
        value = -1;
        for (int i = 0; i < 10; i++) begin
            if (pattern == DIGIT_PATTERNS[i]) begin
                value = i;
            end
        end
        if (pattern == ARROW_UP) begin
            value = 10;
        end else if (pattern == ARROW_DOWN) begin
            value = 11;
        end
        if (value < 0) begin
            fail_run($sformatf("Segment pattern 0x%h is neither a digit nor an arrow", pattern));
        end
    endtask

    task automatic read_display(output count_t count, output direction_t dir);
        int         value;
        int         tens;
        int         ones;
        int         arrow_left;
        int         arrow_right;
        logic [3:0] seen;
        seen        = '0;
        tens        = 0;
        ones        = 0;
        arrow_left  = 0;
        arrow_right = 0;
        // Skip the cycle where seg still shows the old state.
        step_cycle();
        repeat (14) begin
            step_cycle();
            check_display_pattern(seg, value);
            case (an)
                4'b0111: begin
                    tens    = value;
                    seen[0] = 1'b1;
                end
                4'b1011: begin
                    ones    = value;
                    seen[1] = 1'b1;
                end
                4'b1101: begin
                    arrow_left = value;
                    seen[2]    = 1'b1;
                end
                4'b1110: begin
                    arrow_right = value;
                    seen[3]     = 1'b1;
                end
                default: fail_run($sformatf("Anode pattern 0x%h selects no single digit", an));
            endcase
        end
        if (seen != 4'b1111) begin
            fail_run("Not every digit was lit during the scan window");
        end
        if (tens > 1 || ones > 9) begin
            fail_run("The count digits show a symbol that is not a valid count");
        end
        if (arrow_left < 10 || arrow_right < 10) begin
            fail_run("A direction digit shows a number instead of an arrow");
        end
        if (arrow_left != arrow_right) begin
            fail_run("The two direction digits show different arrows");
        end
        count = count_t'(tens * 10 + ones);
        dir   = (arrow_left == 10) ? dir_up : dir_down;
    endtask

    task automatic check_count(input string name, input count_t actual, input count_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR: %s is 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic check_direction(input string name, input direction_t actual,
                                   input direction_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR: %s is 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    // ****************************************
    // Main sequence.
    // ****************************************
    initial begin
        count_t     shown_count;
        direction_t shown_dir;
        int         total;
        rstn_out      = 1'b1;
        switches      = '0;
        flip_button   = 1'b0;
        cycle_count   = 0;
        cycle_limit   = 1000;
        press_left    = 0;
        lfsr_state    = 16'd37467;
        model_count   = '0;
        model_dir     = dir_up;
        model_pending = 1'b0;
        model_first   = 1'b1;
        build_table();
        total = 0;
        for (int i = 0; i < rows.size(); i++) begin
            total += int'(rows[i].periods) + 1;
        end
        cycle_limit = total * COUNT_TICK_PERIOD + MARGIN;

        repeat (10) @(posedge clk);
        #5;
        rstn_out = 1'b0;
        if (an !== ANODES_OFF) begin
            fail_run("A digit is lit right after reset");
        end

        apply_row(rows[0]);
        for (int i = 0; i < rows.size(); i++) begin
            repeat (int'(rows[i].periods)) begin
                wait_tick();
                model_tick(rows[i].settings);
            end
            if (i >= table_rows) begin
                rows[i].exp_count = model_count;
                rows[i].exp_dir   = model_dir;
            end else if (model_count != rows[i].exp_count || model_dir != rows[i].exp_dir) begin
                fail_run($sformatf("The reference model disagrees with table row %0d", i));
            end
            // Next settings reach the core before its next tick.
            if (i + 1 < rows.size()) begin
                apply_row(rows[i + 1]);
            end
            read_display(shown_count, shown_dir);
            check_count("count", shown_count, rows[i].exp_count);
            check_direction("direction", shown_dir, rows[i].exp_dir);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
